//--- pcs_rx_top.f
+incdir+rtl
+incdir+verif
rtl/pcs_block_pkg.sv
rtl/xgmii_pkg.sv
rtl/rx_descrambler.sv
rtl/rx_block_classifier.sv
rtl/rx_decoder_fsm.sv
rtl/pcs_rx_top.sv
verif/pcs_rx_tb.sv

//--- rtl/pcs_block_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block level definitions of the receive PCS.
// Sync header codes, block type field codes, the
// block classes seen by the decoder and the states
// of the receive sequence FSM.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pcs_rx_macros.svh"

package pcs_block_pkg;

	typedef logic [`PCS_HDR_W-1:0] sync_hdr_t;

	localparam sync_hdr_t SH_DATA = 2'b01;
	localparam sync_hdr_t SH_CTRL = 2'b10;

	// first payload byte of a control block.
	typedef logic [7:0] blk_type_t;

	localparam blk_type_t BT_IDLE   = 8'h1E; // all control.
	localparam blk_type_t BT_START0 = 8'h78;
	localparam blk_type_t BT_TERM0  = 8'h87;
	localparam blk_type_t BT_TERM1  = 8'h99;
	localparam blk_type_t BT_TERM2  = 8'hAA;
	localparam blk_type_t BT_TERM3  = 8'hB4;
	localparam blk_type_t BT_TERM4  = 8'hCC;
	localparam blk_type_t BT_TERM5  = 8'hD2;
	localparam blk_type_t BT_TERM6  = 8'hE1;
	localparam blk_type_t BT_TERM7  = 8'hFF;

	// class of a received block.
	typedef enum logic [2:0] {
		TYPE_D,
		TYPE_S,
		TYPE_C,
		TYPE_T,
		TYPE_E
	} r_type_t;

	typedef enum logic [2:0] {
		RX_INIT,
		RX_C,
		RX_D,
		RX_T,
		RX_E
	} rx_state_t;

endpackage

//--- rtl/pcs_rx_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed widths of the 10GBASE-R receive decode path.
// Include this in any file that sizes a block, a
// header, the lane set or the descrambler history.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PCS_RX_MACROS_SVH
`define PCS_RX_MACROS_SVH

`define PCS_DATA_W  64 // block payload, also the XGMII data word.

`define PCS_CTRL_W  8  // XGMII lanes, one control flag each.

`define PCS_HDR_W   2  // sync header.

`define PCS_SCR_LEN 58 // descrambler history, x^58 + x^39 + 1.

`endif

//--- rtl/pcs_rx_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive decode path of a 10GBASE-R style PCS.
// Takes aligned 66-bit blocks marked by i_valid and
// gives XGMII words with a one cycle o_valid pulse.
// Holding i_valid low stalls every stage together.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "pcs_rx_macros.svh"

module pcs_rx_top (
	input  logic                     clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_block_pkg::sync_hdr_t i_header,
	input  logic [`PCS_DATA_W-1:0]   i_payload,
	output xgmii_pkg::xgmii_data_t   o_data,
	output xgmii_pkg::xgmii_ctrl_t   o_ctrl,
	output logic                     o_valid
);
	import pcs_block_pkg::*;
	import xgmii_pkg::*;

	sync_hdr_t              dsc_header; // stage 1 contents.
	logic [`PCS_DATA_W-1:0] dsc_payload;
	logic                   dsc_filled;

	r_type_t     cls_r_type; // stage 2 contents.
	r_type_t     cls_r_type_next;
	xgmii_data_t cls_data;
	xgmii_ctrl_t cls_ctrl;
	logic        cls_primed;

	rx_descrambler u_descrambler (
		.clock     (clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_header  (i_header),
		.i_payload (i_payload),
		.o_header  (dsc_header),
		.o_payload (dsc_payload),
		.o_filled  (dsc_filled)
	);

	rx_block_classifier u_classifier (
		.clock         (clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_header      (dsc_header),
		.i_payload     (dsc_payload),
		.i_filled      (dsc_filled),
		.o_r_type      (cls_r_type),
		.o_r_type_next (cls_r_type_next),
		.o_data        (cls_data),
		.o_ctrl        (cls_ctrl),
		.o_primed      (cls_primed)
	);

	rx_decoder_fsm u_decoder_fsm (
		.clock         (clock),
		.i_reset       (i_reset),
		.i_valid       (i_valid),
		.i_primed      (cls_primed),
		.i_r_type      (cls_r_type),
		.i_r_type_next (cls_r_type_next),
		.i_data        (cls_data),
		.i_ctrl        (cls_ctrl),
		.o_data        (o_data),
		.o_ctrl        (o_ctrl),
		.o_valid       (o_valid)
	);

endmodule

//--- rtl/rx_block_classifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 2 of the receive decode path.
// Classifies the descrambled block as D, S, C, T or E
// and decodes it into an XGMII word. The class of the
// block still in stage 1 is passed on as lookahead.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "pcs_rx_macros.svh"

module rx_block_classifier (
	input  logic                     clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_block_pkg::sync_hdr_t i_header,
	input  logic [`PCS_DATA_W-1:0]   i_payload,
	input  logic                     i_filled,
	output pcs_block_pkg::r_type_t   o_r_type,
	output pcs_block_pkg::r_type_t   o_r_type_next,
	output xgmii_pkg::xgmii_data_t   o_data,
	output xgmii_pkg::xgmii_ctrl_t   o_ctrl,
	output logic                     o_primed
);
	import pcs_block_pkg::*;
	import xgmii_pkg::*;

	localparam int LANE_W = `PCS_DATA_W / `PCS_CTRL_W;
	localparam int CODE_W = 7; // control code in an all-control block.

	blk_type_t                      block_type;
	logic [`PCS_DATA_W-1:0]         body; // payload past the type field.
	logic                           term_hit;
	logic [$clog2(`PCS_CTRL_W)-1:0] term_lane;
	r_type_t                        dec_type;
	xgmii_data_t                    dec_data;
	xgmii_ctrl_t                    dec_ctrl;

	assign block_type = i_payload[LANE_W-1:0];
	assign body = i_payload >> LANE_W;

	// lane of the terminate character.
	always_comb
	begin
		term_hit = 1'b1;
		term_lane = '0;
		case (block_type)
			BT_TERM0: term_lane = 3'd0;
			BT_TERM1: term_lane = 3'd1;
			BT_TERM2: term_lane = 3'd2;
			BT_TERM3: term_lane = 3'd3;
			BT_TERM4: term_lane = 3'd4;
			BT_TERM5: term_lane = 3'd5;
			BT_TERM6: term_lane = 3'd6;
			BT_TERM7: term_lane = 3'd7;
			default:  term_hit = 1'b0;
		endcase
	end

	always_comb
	begin
		dec_type = TYPE_E;
		dec_data = XG_ERR_DATA;
		dec_ctrl = XG_ERR_CTRL;
		if (i_header == SH_DATA)
		begin
			dec_type = TYPE_D;
			dec_data = i_payload;
			dec_ctrl = '0;
		end
		else if (i_header == SH_CTRL)
		begin
			if (block_type == BT_IDLE)
			begin
				dec_type = TYPE_C;
				dec_ctrl = '1;
				for (int j = 0; j < `PCS_CTRL_W; j++)
				begin
					// only code 0x00 is idle here.
					if (i_payload[LANE_W + CODE_W*j +: CODE_W] == '0)
						dec_data[LANE_W*j +: LANE_W] = XG_IDLE;
					else
						dec_data[LANE_W*j +: LANE_W] = XG_ERROR;
				end
			end
			else if (block_type == BT_START0)
			begin
				dec_type = TYPE_S;
				dec_data = {i_payload[`PCS_DATA_W-1:LANE_W], XG_START};
				dec_ctrl = 8'h01;
			end
			else if (term_hit)
			begin
				dec_type = TYPE_T;
				dec_ctrl = XG_ERR_CTRL << term_lane; // data lanes below the terminate.
				for (int j = 0; j < `PCS_CTRL_W; j++)
				begin
					if (j < term_lane)
						dec_data[LANE_W*j +: LANE_W] = body[LANE_W*j +: LANE_W];
					else if (j == term_lane)
						dec_data[LANE_W*j +: LANE_W] = XG_TERM;
					else
						dec_data[LANE_W*j +: LANE_W] = XG_IDLE;
				end
			end
		end
	end

	// empty stage 1 reads as an error block.
	assign o_r_type_next = i_filled ? dec_type : TYPE_E;

	always_ff @(posedge clock or posedge i_reset)
	begin
		if (i_reset)
		begin
			o_r_type <= TYPE_E;
			o_primed <= 1'b0;
		end
		else if (i_valid)
		begin
			o_r_type <= o_r_type_next;
			o_primed <= o_primed | i_filled;
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_valid)
		begin
			o_data <= dec_data;
			o_ctrl <= dec_ctrl;
		end
	end

	a_r_type_legal: assert property (@(posedge clock) disable iff (i_reset)
		o_r_type inside {TYPE_D, TYPE_S, TYPE_C, TYPE_T, TYPE_E});

endmodule

//--- rtl/rx_decoder_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 3, the receive sequence FSM.
// Forwards the decoded word of each block whose place
// in the sequence is legal and puts the error word in
// place of the rest. A terminate is checked against
// the class of the block after it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module rx_decoder_fsm (
	input  logic                   clock,
	input  logic                   i_reset,
	input  logic                   i_valid,
	input  logic                   i_primed,
	input  pcs_block_pkg::r_type_t i_r_type,
	input  pcs_block_pkg::r_type_t i_r_type_next,
	input  xgmii_pkg::xgmii_data_t i_data,
	input  xgmii_pkg::xgmii_ctrl_t i_ctrl,
	output xgmii_pkg::xgmii_data_t o_data,
	output xgmii_pkg::xgmii_ctrl_t o_ctrl,
	output logic                   o_valid
);
	import pcs_block_pkg::*;
	import xgmii_pkg::*;

	rx_state_t state;
	rx_state_t state_next;
	logic      advance;
	logic      next_ok;

	// a decision needs a held block and its successor.
	assign advance = i_valid & i_primed;

	// a terminate must be followed by start or control.
	assign next_ok = (i_r_type_next == TYPE_S) || (i_r_type_next == TYPE_C);

	always_comb
	begin
		state_next = state;
		case (state)
			RX_INIT, RX_C, RX_T:
			begin
				if (i_r_type == TYPE_C)
					state_next = RX_C;
				else if (i_r_type == TYPE_S)
					state_next = RX_D;
				else
					state_next = RX_E;
			end

			RX_D:
			begin
				if (i_r_type == TYPE_D)
					state_next = RX_D;
				else if (i_r_type == TYPE_T && next_ok)
					state_next = RX_T;
				else
					state_next = RX_E; // start or control inside a frame.
			end

			RX_E:
			begin
				if (i_r_type == TYPE_C)
					state_next = RX_C;
				else if (i_r_type == TYPE_S || i_r_type == TYPE_D)
					state_next = RX_D;
				else if (i_r_type == TYPE_T && next_ok)
					state_next = RX_T;
				else
					state_next = RX_E;
			end

			default:
			begin
				state_next = RX_E;
			end
		endcase
	end

	always_ff @(posedge clock or posedge i_reset)
	begin
		if (i_reset)
		begin
			state <= RX_INIT;
			o_data <= XG_LF_DATA; // local fault until the first decision.
			o_ctrl <= XG_LF_CTRL;
			o_valid <= 1'b0;
		end
		else
		begin
			o_valid <= advance; // one cycle pulse.
			if (advance)
			begin
				state <= state_next;
				if (state_next == RX_E)
				begin
					o_data <= XG_ERR_DATA;
					o_ctrl <= XG_ERR_CTRL;
				end
				else
				begin
					o_data <= i_data;
					o_ctrl <= i_ctrl;
				end
			end
		end
	end

	// output words only move on a stalled-free cycle.
	a_valid_after_strobe: assert property (@(posedge clock) disable iff (i_reset)
		o_valid |-> $past(i_valid));

endmodule

//--- rtl/rx_descrambler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stage 1 of the receive decode path.
// Registers the sync header and descrambles the
// payload with the self-synchronizing x^58 + x^39 + 1
// polynomial. Advances only when i_valid is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "pcs_rx_macros.svh"

module rx_descrambler (
	input  logic                     clock,
	input  logic                     i_reset,
	input  logic                     i_valid,
	input  pcs_block_pkg::sync_hdr_t i_header,
	input  logic [`PCS_DATA_W-1:0]   i_payload,
	output pcs_block_pkg::sync_hdr_t o_header,
	output logic [`PCS_DATA_W-1:0]   o_payload,
	output logic                     o_filled
);
	localparam int TAP_B = 38; // x^39 term, x^58 is the top bit.

	logic [`PCS_SCR_LEN-1:0] scr_history; // newest bit at 0.
	logic [`PCS_SCR_LEN-1:0] hist_walk;
	logic [`PCS_DATA_W-1:0]  descr;

	// bit 0 is first on the line.
	always_comb
	begin
		hist_walk = scr_history;
		for (int i = 0; i < `PCS_DATA_W; i++)
		begin
			descr[i] = i_payload[i] ^ hist_walk[TAP_B] ^ hist_walk[`PCS_SCR_LEN-1];
			hist_walk = {hist_walk[`PCS_SCR_LEN-2:0], i_payload[i]}; // history holds line bits.
		end
	end

	always_ff @(posedge clock or posedge i_reset)
	begin
		if (i_reset)
		begin
			scr_history <= '0;
			o_filled <= 1'b0;
		end
		else if (i_valid)
		begin
			scr_history <= hist_walk;
			o_filled <= 1'b1; // a block is now held.
		end
	end

	always_ff @(posedge clock)
	begin
		if (i_valid)
		begin
			o_header <= i_header;
			o_payload <= descr;
		end
	end

	// the whole pipeline stalls on this strobe.
	a_valid_known: assert property (@(posedge clock) disable iff (i_reset)
		!$isunknown(i_valid));

endmodule

//--- rtl/xgmii_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XGMII side definitions of the receive PCS.
// Word types, lane characters and the two fixed
// words the decoder can emit in place of data.
// Lane 0 sits in the low byte of the data word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "pcs_rx_macros.svh"

package xgmii_pkg;

	typedef logic [`PCS_DATA_W-1:0] xgmii_data_t;
	typedef logic [`PCS_CTRL_W-1:0] xgmii_ctrl_t;

	localparam logic [7:0] XG_IDLE  = 8'h07;
	localparam logic [7:0] XG_START = 8'hFB;
	localparam logic [7:0] XG_TERM  = 8'hFD;
	localparam logic [7:0] XG_ERROR = 8'hFE;
	localparam logic [7:0] XG_SEQ   = 8'h9C;

	// local fault, sequence in lanes 0 and 4.
	localparam xgmii_data_t XG_LF_DATA = {
		8'h01, 8'h00, 8'h00, XG_SEQ,
		8'h01, 8'h00, 8'h00, XG_SEQ
	};
	localparam xgmii_ctrl_t XG_LF_CTRL = 8'h11;

	// replaces any block that breaks the sequence.
	localparam xgmii_data_t XG_ERR_DATA = {`PCS_CTRL_W{XG_ERROR}};
	localparam xgmii_ctrl_t XG_ERR_CTRL = {`PCS_CTRL_W{1'b1}};

endpackage

//--- verif/pcs_rx_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference side of the receive PCS testbench.
// Line scrambler, block builders and a decode model
// of block classes, XGMII lanes and the sequence FSM.
// Included inside the testbench module body.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PCS_RX_MODEL_SVH
`define PCS_RX_MODEL_SVH

localparam blk_type_t TERM_CODES [8] = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
	BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7}; // indexed by terminate lane.

// s(n) = d(n) ^ s(n-39) ^ s(n-58), bit 0 goes out first.
task automatic scramble_payload(input logic [`PCS_DATA_W-1:0] plain,
	output logic [`PCS_DATA_W-1:0] line, inout logic [`PCS_SCR_LEN-1:0] hist);
	for (int i = 0; i < `PCS_DATA_W; i++)
	begin
		line[i] = plain[i] ^ hist[38] ^ hist[`PCS_SCR_LEN-1];
		hist = {hist[`PCS_SCR_LEN-2:0], line[i]};
	end
endtask

function automatic int term_lane_of(input blk_type_t t);
	for (int k = 0; k < `PCS_CTRL_W; k++)
	begin
		if (TERM_CODES[k] == t)
			return k;
	end
	return -1; // not a terminate.
endfunction

function automatic logic [`PCS_DATA_W-1:0] idle_payload();
	logic [55:0] codes;
	codes = '0;
	for (int j = 0; j < `PCS_CTRL_W; j++)
	begin
		if ($urandom % 8 == 0)
			codes[7*j +: 7] = 7'(1 + $urandom % 127); // an error lane.
	end
	return {codes, BT_IDLE};
endfunction

// random body under a given type field.
function automatic logic [`PCS_DATA_W-1:0] control_payload(input blk_type_t t);
	logic [`PCS_DATA_W-1:0] p;
	p = {$urandom, $urandom};
	p[7:0] = t;
	return p;
endfunction

function automatic blk_type_t unsupported_type();
	blk_type_t t;
	t = BT_IDLE;
	while (t == BT_IDLE || t == BT_START0 || term_lane_of(t) >= 0)
		t = 8'($urandom);
	return t;
endfunction

function automatic r_type_t model_class(input sync_hdr_t h, input logic [`PCS_DATA_W-1:0] p);
	if (h == SH_DATA)
		return TYPE_D;
	else if (h != SH_CTRL)
		return TYPE_E;
	else if (p[7:0] == BT_IDLE)
		return TYPE_C;
	else if (p[7:0] == BT_START0)
		return TYPE_S;
	else if (term_lane_of(p[7:0]) >= 0)
		return TYPE_T;
	else
		return TYPE_E;
endfunction

// lane j of the word is byte j of d.
task automatic model_decode(input sync_hdr_t h, input logic [`PCS_DATA_W-1:0] p,
	output xgmii_data_t d, output xgmii_ctrl_t c);
	int k;
	d = XG_ERR_DATA;
	c = XG_ERR_CTRL;
	k = term_lane_of(p[7:0]);
	case (model_class(h, p))
		TYPE_D:
		begin
			d = p;
			c = '0;
		end
		TYPE_C:
		begin
			for (int j = 0; j < `PCS_CTRL_W; j++)
				d[8*j +: 8] = (p[8 + 7*j +: 7] == 7'd0) ? XG_IDLE : XG_ERROR;
		end
		TYPE_S:
		begin
			d = p;
			d[7:0] = XG_START;
			c = 8'h01;
		end
		TYPE_T:
		begin
			c = '0;
			for (int j = 0; j < `PCS_CTRL_W; j++)
			begin
				if (j < k)
					d[8*j +: 8] = p[8*j + 8 +: 8]; // data shifted down past the type.
				else
				begin
					c[j] = 1'b1;
					d[8*j +: 8] = (j == k) ? XG_TERM : XG_IDLE;
				end
			end
		end
		default:
		begin
		end
	endcase
endtask

function automatic rx_state_t model_next_state(input rx_state_t st, input r_type_t cur,
	input r_type_t nxt);
	logic term_ok;
	term_ok = (cur == TYPE_T) && (nxt == TYPE_S || nxt == TYPE_C);
	if (st == RX_D)
	begin
		if (cur == TYPE_D)
			return RX_D;
		return term_ok ? RX_T : RX_E;
	end
	if (cur == TYPE_C)
		return RX_C;
	if (cur == TYPE_S)
		return RX_D;
	if (st == RX_E && cur == TYPE_D)
		return RX_D; // data resyncs after an error.
	if (st == RX_E && term_ok)
		return RX_T;
	return RX_E;
endfunction

`endif

//--- verif/pcs_rx_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the receive PCS decode path.
// Builds random frames and error cases, scrambles
// them, drives them with gaps in i_valid and checks
// every XGMII word against the reference model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "pcs_rx_macros.svh"

module pcs_rx_tb;
	import pcs_block_pkg::*;
	import xgmii_pkg::*;

	`include "pcs_rx_model.svh"

	logic                   clock = 1'b0;
	logic                   i_reset;
	logic                   i_valid;
	sync_hdr_t              i_header;
	logic [`PCS_DATA_W-1:0] i_payload;
	xgmii_data_t            o_data;
	xgmii_ctrl_t            o_ctrl;
	logic                   o_valid;

	sync_hdr_t              hdr_q[$]; // plain blocks in send order.
	logic [`PCS_DATA_W-1:0] plain_q[$];
	xgmii_data_t            exp_data_q[$];
	xgmii_ctrl_t            exp_ctrl_q[$];
	xgmii_data_t            last_data = XG_LF_DATA; // word the outputs must hold.
	xgmii_ctrl_t            last_ctrl = XG_LF_CTRL;
	logic                   pulse_due = 1'b0;
	int                     taken_count = 0;
	int                     words_checked = 0;
	int                     cycle_count = 0;
	int                     cycle_limit = 0;

	pcs_rx_top UUT (
		.clock     (clock),
		.i_reset   (i_reset),
		.i_valid   (i_valid),
		.i_header  (i_header),
		.i_payload (i_payload),
		.o_data    (o_data),
		.o_ctrl    (o_ctrl),
		.o_valid   (o_valid)
	);

	always #20 clock = ~clock;

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_xgmii(input xgmii_data_t got_data, input xgmii_ctrl_t got_ctrl,
		input xgmii_data_t exp_data, input xgmii_ctrl_t exp_ctrl);
		if (got_data !== exp_data || got_ctrl !== exp_ctrl)
			stop_on_error($sformatf("ERROR at %0t ns: word %0d is %h/%h, expected %h/%h",
				$time, words_checked, got_data, got_ctrl, exp_data, exp_ctrl));
	endtask

	task automatic check_no_valid(input logic got_pulse, input logic due_pulse, input int queued);
		if (got_pulse !== due_pulse)
			stop_on_error($sformatf("ERROR at %0t ns: o_valid is %b, expected %b",
				$time, got_pulse, due_pulse));
		if (got_pulse && queued == 0)
			stop_on_error("o_valid pulsed but the model has no word left to compare");
	endtask

	task automatic push_block(input sync_hdr_t h, input logic [`PCS_DATA_W-1:0] p);
		hdr_q.push_back(h);
		plain_q.push_back(p);
	endtask

	task automatic put_c();
		push_block(SH_CTRL, idle_payload());
	endtask

	task automatic put_s();
		push_block(SH_CTRL, control_payload(BT_START0));
	endtask

	task automatic put_d();
		push_block(SH_DATA, {$urandom, $urandom});
	endtask

	task automatic put_t();
		push_block(SH_CTRL, control_payload(TERM_CODES[$urandom % 8]));
	endtask

	task automatic add_legal_frame();
		repeat (1 + $urandom % 3)
			put_c();
		put_s();
		repeat ($urandom % 6)
			put_d();
		put_t();
		put_c();
	endtask

	// D and T after C, then S inside a frame.
	task automatic add_sequence_errors();
		put_c();
		put_d();
		put_c();
		put_t();
		put_s();
		put_d();
		put_t();
		put_c();
		put_s();
		put_d();
		put_s();
		put_d();
		put_t();
		put_c();
	endtask

	// terminates followed by D, T and an error block.
	task automatic add_lookahead_errors();
		put_s();
		put_d();
		put_t();
		put_d();
		put_t();
		put_t();
		put_c();
		put_s();
		put_t();
		push_block(2'b11, {$urandom, $urandom});
		put_c();
	endtask

	task automatic add_bad_blocks();
		push_block(2'b00, {$urandom, $urandom});
		push_block(2'b11, {$urandom, $urandom});
		push_block(SH_CTRL, control_payload(unsupported_type()));
		put_c();
	endtask

	// the last two blocks are never decided.
	task automatic build_expected();
		rx_state_t   st;
		xgmii_data_t d;
		xgmii_ctrl_t c;
		st = RX_INIT;
		for (int n = 0; n + 2 < hdr_q.size(); n++)
		begin
			st = model_next_state(st, model_class(hdr_q[n], plain_q[n]),
				model_class(hdr_q[n+1], plain_q[n+1]));
			model_decode(hdr_q[n], plain_q[n], d, c);
			exp_data_q.push_back((st == RX_E) ? XG_ERR_DATA : d);
			exp_ctrl_q.push_back((st == RX_E) ? XG_ERR_CTRL : c);
		end
	endtask

	// a pulse follows each valid cycle once two blocks are held.
	always @(posedge clock)
	begin
		if (i_reset)
		begin
			pulse_due <= 1'b0;
			taken_count <= 0;
		end
		else
		begin
			pulse_due <= i_valid && (taken_count >= 2);
			if (i_valid)
				taken_count <= taken_count + 1;
		end
	end

	always @(negedge clock)
	begin
		if (!i_reset)
		begin
			check_no_valid(o_valid, pulse_due, exp_data_q.size());
			if (o_valid)
			begin
				last_data = exp_data_q.pop_front();
				last_ctrl = exp_ctrl_q.pop_front();
			end
			check_xgmii(o_data, o_ctrl, last_data, last_ctrl); // new word or the held one.
			if (o_valid)
				words_checked++;
		end
	end

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout after %0d cycles with %0d words still expected",
				cycle_count, exp_data_q.size());
			$display("TEST FAIL");
			$fatal(1, "run ended by the cycle limit");
		end
	end

	initial
	begin
		logic [`PCS_SCR_LEN-1:0] scr_hist;
		logic [`PCS_DATA_W-1:0]  line_word;
		void'($urandom(98));
		scr_hist = '0; // matches the descrambler after reset.
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_header = '0;
		i_payload = '0;
		repeat (6)
			add_legal_frame();
		add_sequence_errors();
		add_lookahead_errors();
		add_bad_blocks();
		repeat (150)
		begin
			case ($urandom % 4)
				0: add_legal_frame();
				1: add_sequence_errors();
				2: add_lookahead_errors();
				default: add_bad_blocks();
			endcase
		end
		put_c();
		put_c();
		build_expected();
		cycle_limit = hdr_q.size() * 3 + 100;
		repeat (2) @(posedge clock);
		i_reset <= 1'b0;
		for (int i = 0; i < hdr_q.size(); i++)
		begin
			@(posedge clock);
			while ($urandom % 5 == 0)
			begin
				i_valid <= 1'b0; // gap with junk on the bus.
				i_header <= 2'($urandom);
				i_payload <= {$urandom, $urandom};
				@(posedge clock);
			end
			scramble_payload(plain_q[i], line_word, scr_hist);
			i_valid <= 1'b1;
			i_header <= hdr_q[i];
			i_payload <= line_word;
		end
		@(posedge clock);
		i_valid <= 1'b0;
		while (exp_data_q.size() != 0)
			@(posedge clock);
		repeat (4) @(posedge clock);
		$display("TEST PASS");
		$finish;
	end

endmodule
